// File: design/radio_ctrl_params.svh
/*
 * Shared constants for the DSP-clock control plane: settings-bus
 * addresses and widths, register offsets, reset values, the default
 * tick rate and the compatibility number. Include wherever a macro
 * is needed; the guard makes repeated includes harmless.
 */
`ifndef RADIO_CTRL_PARAMS_SVH
`define RADIO_CTRL_PARAMS_SVH

// Settings bus widths
`define RADIO_SET_ADDR_W     8
`define RADIO_SET_DATA_W     32
`define RADIO_RB_ADDR_W      4

// Block base addresses and the span each block owns
`define RADIO_SR_MISC        0
`define RADIO_MISC_SPAN      8
`define RADIO_SR_TIME64      10
`define RADIO_TIME_SPAN      3

// Offsets within the misc block
`define RADIO_MISC_CLK       4'd0
`define RADIO_MISC_SER       4'd1
`define RADIO_MISC_ADC       4'd2
`define RADIO_MISC_LED       4'd3
`define RADIO_MISC_PHY       4'd4
`define RADIO_MISC_LED_SRC   4'd6

// Offsets within the time block
`define RADIO_TIME_SECS      4'd0
`define RADIO_TIME_TICKS     4'd1
`define RADIO_TIME_MODE      4'd2

// LEDs 1 to 4 follow hardware status out of reset
`define RADIO_LED_SRC_RESET  8'b0001_1110

// Bump when the register map changes in a way software must see
`define RADIO_COMPAT_NUM     32'd6

`define RADIO_TICKS_PER_SEC  100000000
`define RADIO_RB_WORDS       16

`endif

// File: design/radio_ctrl_pkg.sv
/*
 * Types shared by the control-plane modules: settings-bus address and
 * data, the owning-block select, the packed pin groups of the misc
 * registers, the LED vector, VITA time and the readback address.
 * Compile before every module that refers to it.
 */
package radio_ctrl_pkg;

`include "radio_ctrl_params.svh"

   typedef logic [`RADIO_SET_ADDR_W-1:0] set_addr_t;
   typedef logic [`RADIO_SET_DATA_W-1:0] set_data_t;

   // Block that owns a settings address
   typedef enum logic [1:0] {
      BLK_NONE,
      BLK_MISC,
      BLK_LED,
      BLK_TIME
   } block_sel_t;

   // Clock generator pins, MSB first as on the bus
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clk_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } ser_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef logic [7:0] led_t;

   // Seconds in the upper word, ticks in the lower
   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_time_t;

   typedef logic [`RADIO_RB_ADDR_W-1:0] rb_addr_t;

endpackage

// File: design/time_if.sv
/*
 * Time state handed from the VITA timer to the readback mux.
 * The timer drives it through modport timer, the mux reads it
 * through modport reader.
 */
interface time_if;

   import radio_ctrl_pkg::*;

   // Running time, time latched at the last PPS, and sticky PPS flag
   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   logic       pps_seen;

   modport timer (
      output vita_time,
      output vita_time_pps,
      output pps_seen
   );

   modport reader (
      input vita_time,
      input vita_time_pps,
      input pps_seen
   );

endinterface

// File: design/settings_decoder.sv
/*
 * Settings-bus front end. Registers every write, decides which block
 * owns the address and issues a one-cycle strobe to that block along
 * with the offset inside the block and the data. Addresses owned by
 * nobody are dropped. The strobe appears one cycle after the write
 * is registered.
 */
module settings_decoder (
   input  logic                    dsp_clk,
   input  logic                    reset_i,
   input  logic                    set_stb_i,
   input  radio_ctrl_pkg::set_addr_t set_addr_i,
   input  radio_ctrl_pkg::set_data_t set_data_i,
   output logic                    misc_stb_o,
   output logic                    led_stb_o,
   output logic                    time_stb_o,
   output logic [3:0]              offset_o,
   output radio_ctrl_pkg::set_data_t data_o
);

`include "radio_ctrl_params.svh"

   import radio_ctrl_pkg::*;

   logic       wr_stb_q;
   set_addr_t  wr_addr_q;
   set_data_t  wr_data_q;
   set_addr_t  misc_rel;
   set_addr_t  time_rel;
   block_sel_t blk_sel;
   logic [3:0] rel_addr;

   // Offsets against each base; below-base addresses wrap to large values
   assign misc_rel = wr_addr_q - set_addr_t'(`RADIO_SR_MISC);
   assign time_rel = wr_addr_q - set_addr_t'(`RADIO_SR_TIME64);

   always_comb begin
      blk_sel  = BLK_NONE;
      rel_addr = '0;
      if (misc_rel < set_addr_t'(`RADIO_MISC_SPAN)) begin
         rel_addr = misc_rel[3:0];
         // LED registers sit inside the misc window but belong elsewhere
         if (rel_addr == `RADIO_MISC_LED || rel_addr == `RADIO_MISC_LED_SRC) begin
            blk_sel = BLK_LED;
         end else begin
            blk_sel = BLK_MISC;
         end
      end else if (time_rel < set_addr_t'(`RADIO_TIME_SPAN)) begin
         rel_addr = time_rel[3:0];
         blk_sel  = BLK_TIME;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         wr_stb_q   <= 1'b0;
         misc_stb_o <= 1'b0;
         led_stb_o  <= 1'b0;
         time_stb_o <= 1'b0;
      end else begin
         wr_stb_q   <= set_stb_i;
         misc_stb_o <= wr_stb_q && (blk_sel == BLK_MISC);
         led_stb_o  <= wr_stb_q && (blk_sel == BLK_LED);
         time_stb_o <= wr_stb_q && (blk_sel == BLK_TIME);
      end
   end

   // Address and data just ride along with the strobes
   always_ff @(posedge dsp_clk) begin
      wr_addr_q <= set_addr_i;
      wr_data_q <= set_data_i;
      offset_o  <= rel_addr;
      data_o    <= wr_data_q;
   end

endmodule

// File: design/misc_ctrl_regs.sv
/*
 * Misc control registers: clock generator, SERDES, ADC and PHY reset.
 * Each register takes the low bits of the settings data when the misc
 * strobe arrives with its offset, and drives its pins directly.
 */
module misc_ctrl_regs (
   input  logic                      dsp_clk,
   input  logic                      reset_i,
   input  logic                      misc_stb_i,
   input  logic [3:0]                offset_i,
   input  radio_ctrl_pkg::set_data_t data_i,
   output radio_ctrl_pkg::clk_ctrl_t clk_ctrl_o,
   output radio_ctrl_pkg::ser_ctrl_t ser_ctrl_o,
   output radio_ctrl_pkg::adc_ctrl_t adc_ctrl_o,
   output logic                      phy_resetn_o
);

`include "radio_ctrl_params.svh"

   import radio_ctrl_pkg::*;

   clk_ctrl_t clk_ctrl_q;
   ser_ctrl_t ser_ctrl_q;
   adc_ctrl_t adc_ctrl_q;
   logic      phy_reset_q;

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         clk_ctrl_q  <= '0;
         ser_ctrl_q  <= '0;
         adc_ctrl_q  <= '0;
         phy_reset_q <= 1'b0;
      end else if (misc_stb_i) begin
         case (offset_i)
            `RADIO_MISC_CLK: clk_ctrl_q <= clk_ctrl_t'(data_i[$bits(clk_ctrl_t)-1:0]);
            `RADIO_MISC_SER: ser_ctrl_q <= ser_ctrl_t'(data_i[$bits(ser_ctrl_t)-1:0]);
            `RADIO_MISC_ADC: adc_ctrl_q <= adc_ctrl_t'(data_i[$bits(adc_ctrl_t)-1:0]);
            `RADIO_MISC_PHY: phy_reset_q <= data_i[0];
            default: begin
               // Other misc offsets hold nothing here
            end
         endcase
      end
   end

   assign clk_ctrl_o = clk_ctrl_q;
   assign ser_ctrl_o = ser_ctrl_q;
   assign adc_ctrl_o = adc_ctrl_q;

   // PHY reset pin is active low
   assign phy_resetn_o = ~phy_reset_q;

endmodule

// File: design/led_select.sv
/*
 * LED control. A software value register and a source register pick,
 * bit by bit, between software and hardware status. A source bit of 1
 * hands that LED to hardware. run_rx is registered once before use.
 */
module led_select (
   input  logic                      dsp_clk,
   input  logic                      reset_i,
   input  logic                      led_stb_i,
   input  logic [3:0]                offset_i,
   input  radio_ctrl_pkg::set_data_t data_i,
   input  logic                      run_rx_i,
   input  logic                      run_tx_i,
   input  logic                      clk_status_i,
   input  logic                      link_up_i,
   output radio_ctrl_pkg::led_t      leds_o
);

`include "radio_ctrl_params.svh"

   import radio_ctrl_pkg::*;

   led_t led_sw_q;
   led_t led_src_q;
   led_t led_hw;
   logic run_rx_d1;

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         led_sw_q  <= '0;
         led_src_q <= `RADIO_LED_SRC_RESET;
      end else if (led_stb_i) begin
         if (offset_i == `RADIO_MISC_LED) begin
            led_sw_q <= data_i[$bits(led_t)-1:0];
         end
         if (offset_i == `RADIO_MISC_LED_SRC) begin
            led_src_q <= data_i[$bits(led_t)-1:0];
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         run_rx_d1 <= 1'b0;
      end else begin
         run_rx_d1 <= run_rx_i;
      end
   end

   // Bit 0 has no hardware source
   assign led_hw = {3'b000, run_tx_i, run_rx_d1, clk_status_i, link_up_i, 1'b0};

   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

// File: design/vita_timer.sv
/*
 * 64-bit VITA time: seconds and ticks, one tick per dsp_clk cycle.
 * Software writes SECS then TICKS; the TICKS write triggers the set.
 * MODE bit 0 chooses between loading at once and loading at the next
 * PPS rising edge. Every PPS edge latches the time and sets pps_seen.
 */
module vita_timer #(
   parameter int unsigned TICKS_PER_SEC = 100000000
) (
   input  logic                      dsp_clk,
   input  logic                      reset_i,
   input  logic                      time_stb_i,
   input  logic [3:0]                offset_i,
   input  radio_ctrl_pkg::set_data_t data_i,
   input  logic                      pps_i,
   time_if.timer                     tif
);

`include "radio_ctrl_params.svh"

   import radio_ctrl_pkg::*;

   localparam logic [31:0] LAST_TICK = 32'(TICKS_PER_SEC - 1);

   vita_time_t time_q;
   vita_time_t time_nxt;
   vita_time_t time_pps_q;
   logic [31:0] pend_secs;
   logic [31:0] pend_ticks;
   logic        mode_q;
   logic        armed_q;
   logic        pps_d1;
   logic        pps_d2;
   logic        pps_edge;
   logic        pps_seen_q;
   logic        ticks_wr;
   logic        imm_set;
   logic        pps_set;

   ////////////////////////////////////////////////////////////////////////////
   // Settings writes

   assign ticks_wr = time_stb_i && (offset_i == `RADIO_TIME_TICKS);
   assign imm_set  = ticks_wr && !mode_q;
   assign pps_set  = pps_edge && armed_q && !imm_set;

   // Pending value, loaded later by the TICKS write or a PPS edge
   always_ff @(posedge dsp_clk) begin
      if (time_stb_i && offset_i == `RADIO_TIME_SECS) begin
         pend_secs <= data_i;
      end
      if (ticks_wr) begin
         pend_ticks <= data_i;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         mode_q  <= 1'b0;
         armed_q <= 1'b0;
      end else begin
         if (time_stb_i && offset_i == `RADIO_TIME_MODE) begin
            mode_q <= data_i[0];
         end
         if (ticks_wr) begin
            armed_q <= mode_q;
         end else if (pps_set) begin
            armed_q <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // PPS edge detect

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         pps_d1 <= 1'b0;
         pps_d2 <= 1'b0;
      end else begin
         pps_d1 <= pps_i;
         pps_d2 <= pps_d1;
      end
   end

   assign pps_edge = pps_d1 && !pps_d2;

   ////////////////////////////////////////////////////////////////////////////
   // Counter

   always_comb begin
      time_nxt = time_q;
      if (imm_set) begin
         // Ticks come straight off the bus on the strobe cycle
         time_nxt.secs  = pend_secs;
         time_nxt.ticks = data_i;
      end else if (pps_set) begin
         time_nxt.secs  = pend_secs;
         time_nxt.ticks = pend_ticks;
      end else if (time_q.ticks == LAST_TICK) begin
         time_nxt.secs  = time_q.secs + 32'd1;
         time_nxt.ticks = '0;
      end else begin
         time_nxt.ticks = time_q.ticks + 32'd1;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         time_q     <= '0;
         pps_seen_q <= 1'b0;
      end else begin
         time_q <= time_nxt;
         if (pps_edge) begin
            pps_seen_q <= 1'b1;
         end
      end
   end

   // Latch reflects a set that lands on the same edge
   always_ff @(posedge dsp_clk) begin
      if (pps_edge) begin
         time_pps_q <= time_nxt;
      end
   end

   assign tif.vita_time     = time_q;
   assign tif.vita_time_pps = time_pps_q;
   assign tif.pps_seen      = pps_seen_q;

endmodule

// File: design/readback_mux.sv
/*
 * Status readback. Sixteen 32-bit words selected by rb_addr_i,
 * registered once; the word shows up the cycle after the address
 * is sampled. Unassigned words read as zero.
 */
module readback_mux (
   input  logic                      dsp_clk,
   input  logic                      reset_i,
   input  radio_ctrl_pkg::rb_addr_t  rb_addr_i,
   input  logic                      sim_mode_i,
   input  logic [3:0]                clock_divider_i,
   time_if.reader                    tif,
   output radio_ctrl_pkg::set_data_t rb_data_o
);

`include "radio_ctrl_params.svh"

   import radio_ctrl_pkg::*;

   set_data_t rb_words [`RADIO_RB_WORDS];

   always_comb begin
      for (int i = 0; i < `RADIO_RB_WORDS; i++) begin
         rb_words[i] = '0;
      end
      rb_words[0] = `RADIO_COMPAT_NUM;
      rb_words[1] = {sim_mode_i, 27'b0, clock_divider_i};
      // Current time
      rb_words[2] = tif.vita_time.secs;
      rb_words[3] = tif.vita_time.ticks;
      // Time at the last PPS edge
      rb_words[4] = tif.vita_time_pps.secs;
      rb_words[5] = tif.vita_time_pps.ticks;
      rb_words[6] = {31'b0, tif.pps_seen};
   end

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         rb_data_o <= '0;
      end else begin
         rb_data_o <= rb_words[rb_addr_i];
      end
   end

endmodule

// File: design/radio_ctrl_top.sv
/*
 * Control plane on dsp_clk. Settings writes go through the decoder to
 * the misc, LED and time blocks; status and time come back through
 * the readback mux. Pin groups are unpacked here onto plain ports.
 */
`include "radio_ctrl_params.svh"

module radio_ctrl_top #(
   parameter int unsigned TICKS_PER_SEC = `RADIO_TICKS_PER_SEC
) (
   input  logic                      dsp_clk,
   input  logic                      reset_i,
   // Settings bus
   input  logic                      set_stb_i,
   input  radio_ctrl_pkg::set_addr_t set_addr_i,
   input  radio_ctrl_pkg::set_data_t set_data_i,
   // Timing and status
   input  logic                      pps_i,
   input  logic                      run_rx_i,
   input  logic                      run_tx_i,
   input  logic                      clk_status_i,
   input  logic                      link_up_i,
   input  logic                      sim_mode_i,
   input  logic [3:0]                clock_divider_i,
   // Readback
   input  radio_ctrl_pkg::rb_addr_t  rb_addr_i,
   output radio_ctrl_pkg::set_data_t rb_data_o,
   // Pins
   output radio_ctrl_pkg::led_t      leds_o,
   output logic                      clock_ready_o,
   output logic [1:0]                clk_en_o,
   output logic [1:0]                clk_sel_o,
   output logic                      ser_enable_o,
   output logic                      ser_prbsen_o,
   output logic                      ser_loopen_o,
   output logic                      ser_rx_en_o,
   output logic                      adc_oe_a_o,
   output logic                      adc_on_a_o,
   output logic                      adc_oe_b_o,
   output logic                      adc_on_b_o,
   output logic                      phy_resetn_o
);

   import radio_ctrl_pkg::*;

   logic       misc_stb;
   logic       led_stb;
   logic       time_stb;
   logic [3:0] set_offset;
   set_data_t  set_data;
   clk_ctrl_t  clk_ctrl;
   ser_ctrl_t  ser_ctrl;
   adc_ctrl_t  adc_ctrl;

   time_if time_bus ();

   settings_decoder settings_decoder_i (
      .dsp_clk    (dsp_clk),
      .reset_i    (reset_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .misc_stb_o (misc_stb),
      .led_stb_o  (led_stb),
      .time_stb_o (time_stb),
      .offset_o   (set_offset),
      .data_o     (set_data)
   );

   misc_ctrl_regs misc_ctrl_regs_i (
      .dsp_clk      (dsp_clk),
      .reset_i      (reset_i),
      .misc_stb_i   (misc_stb),
      .offset_i     (set_offset),
      .data_i       (set_data),
      .clk_ctrl_o   (clk_ctrl),
      .ser_ctrl_o   (ser_ctrl),
      .adc_ctrl_o   (adc_ctrl),
      .phy_resetn_o (phy_resetn_o)
   );

   led_select led_select_i (
      .dsp_clk      (dsp_clk),
      .reset_i      (reset_i),
      .led_stb_i    (led_stb),
      .offset_i     (set_offset),
      .data_i       (set_data),
      .run_rx_i     (run_rx_i),
      .run_tx_i     (run_tx_i),
      .clk_status_i (clk_status_i),
      .link_up_i    (link_up_i),
      .leds_o       (leds_o)
   );

   vita_timer #(
      .TICKS_PER_SEC (TICKS_PER_SEC)
   ) vita_timer_i (
      .dsp_clk    (dsp_clk),
      .reset_i    (reset_i),
      .time_stb_i (time_stb),
      .offset_i   (set_offset),
      .data_i     (set_data),
      .pps_i      (pps_i),
      .tif        (time_bus.timer)
   );

   readback_mux readback_mux_i (
      .dsp_clk         (dsp_clk),
      .reset_i         (reset_i),
      .rb_addr_i       (rb_addr_i),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .tif             (time_bus.reader),
      .rb_data_o       (rb_data_o)
   );

   // Pin groups onto the board-level ports
   assign clock_ready_o = clk_ctrl.clock_ready;
   assign clk_en_o      = clk_ctrl.clk_en;
   assign clk_sel_o     = clk_ctrl.clk_sel;
   assign ser_enable_o  = ser_ctrl.enable;
   assign ser_prbsen_o  = ser_ctrl.prbsen;
   assign ser_loopen_o  = ser_ctrl.loopen;
   assign ser_rx_en_o   = ser_ctrl.rx_en;
   assign adc_oe_a_o    = adc_ctrl.oe_a;
   assign adc_on_a_o    = adc_ctrl.on_a;
   assign adc_oe_b_o    = adc_ctrl.oe_b;
   assign adc_on_b_o    = adc_ctrl.on_b;

endmodule

// File: testbench/tb_radio_ctrl_top.sv
/*
 * Testbench for the DSP-clock control plane. Drives settings writes,
 * status inputs and PPS on the falling edge, and checks the pins,
 * LEDs and readback words against shadow registers kept here. The
 * timer runs at 20 ticks per second so that seconds roll quickly.
 * Stops at the first mismatch.
 */
module tb_radio_ctrl_top;

   timeunit 1ns;
   timeprecision 100ps;

`include "radio_ctrl_params.svh"

   import radio_ctrl_pkg::*;

   localparam int unsigned TICKS      = 20;
   localparam int          READ_LIMIT = 100;

   logic      dsp_clk;
   logic      reset_i;
   logic      set_stb_i;
   set_addr_t set_addr_i;
   set_data_t set_data_i;
   logic      pps_i;
   logic      run_rx_i;
   logic      run_tx_i;
   logic      clk_status_i;
   logic      link_up_i;
   logic      sim_mode_i;
   logic [3:0] clock_divider_i;
   rb_addr_t  rb_addr_i;
   set_data_t rb_data_o;
   led_t      leds_o;
   logic      clock_ready_o;
   logic [1:0] clk_en_o;
   logic [1:0] clk_sel_o;
   logic      ser_enable_o;
   logic      ser_prbsen_o;
   logic      ser_loopen_o;
   logic      ser_rx_en_o;
   logic      adc_oe_a_o;
   logic      adc_on_a_o;
   logic      adc_oe_b_o;
   logic      adc_on_b_o;
   logic      phy_resetn_o;

   integer seed = 23756;

   // Shadow registers
   clk_ctrl_t m_clk;
   ser_ctrl_t m_ser;
   adc_ctrl_t m_adc;
   logic      m_phy;
   led_t      m_led_sw;
   led_t      m_led_src;

   radio_ctrl_top #(
      .TICKS_PER_SEC (TICKS)
   ) radio_ctrl_top_i (
      .dsp_clk         (dsp_clk),
      .reset_i         (reset_i),
      .set_stb_i       (set_stb_i),
      .set_addr_i      (set_addr_i),
      .set_data_i      (set_data_i),
      .pps_i           (pps_i),
      .run_rx_i        (run_rx_i),
      .run_tx_i        (run_tx_i),
      .clk_status_i    (clk_status_i),
      .link_up_i       (link_up_i),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .rb_addr_i       (rb_addr_i),
      .rb_data_o       (rb_data_o),
      .leds_o          (leds_o),
      .clock_ready_o   (clock_ready_o),
      .clk_en_o        (clk_en_o),
      .clk_sel_o       (clk_sel_o),
      .ser_enable_o    (ser_enable_o),
      .ser_prbsen_o    (ser_prbsen_o),
      .ser_loopen_o    (ser_loopen_o),
      .ser_rx_en_o     (ser_rx_en_o),
      .adc_oe_a_o      (adc_oe_a_o),
      .adc_on_a_o      (adc_on_a_o),
      .adc_oe_b_o      (adc_oe_b_o),
      .adc_on_b_o      (adc_on_b_o),
      .phy_resetn_o    (phy_resetn_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #50 dsp_clk = ~dsp_clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reporting and compare tasks

   task automatic stop_run(string what);
      $display("%s", what);
      $display("tests failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
      stop_run($sformatf("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                         $time, name, got, exp));
   endtask

   task automatic check_word(string name, set_data_t got, set_data_t exp);
      if (got !== exp) report_mismatch(name, got, exp);
   endtask

   task automatic check_leds(led_t got, led_t exp);
      if (got !== exp) report_mismatch("leds_o", got, exp);
   endtask

   task automatic check_ctrl(clk_ctrl_t got_clk, ser_ctrl_t got_ser, adc_ctrl_t got_adc,
                             logic got_phyn, clk_ctrl_t exp_clk, ser_ctrl_t exp_ser,
                             adc_ctrl_t exp_adc, logic exp_phyn);
      if (got_clk !== exp_clk) report_mismatch("clock pins", got_clk, exp_clk);
      if (got_ser !== exp_ser) report_mismatch("SERDES pins", got_ser, exp_ser);
      if (got_adc !== exp_adc) report_mismatch("ADC pins", got_adc, exp_adc);
      if (got_phyn !== exp_phyn) report_mismatch("phy_resetn_o", got_phyn, exp_phyn);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Model and bus tasks

   // Source bit 1 picks the hardware bit, 0 the software bit
   function automatic led_t expected_leds(led_t src, led_t sw, logic tx, logic rx_d,
                                          logic cs, logic lu);
      led_t hw;
      led_t res;
      hw = 8'h00;
      hw[4] = tx;
      hw[3] = rx_d;
      hw[2] = cs;
      hw[1] = lu;
      for (int i = 0; i < 8; i++) begin
         res[i] = src[i] ? hw[i] : sw[i];
      end
      return res;
   endfunction

   task automatic apply_model_write(set_addr_t addr, set_data_t data);
      case (addr)
         8'd0: m_clk = clk_ctrl_t'(data[4:0]);
         8'd1: m_ser = ser_ctrl_t'(data[3:0]);
         8'd2: m_adc = adc_ctrl_t'(data[3:0]);
         8'd3: m_led_sw = data[7:0];
         8'd4: m_phy = data[0];
         8'd6: m_led_src = data[7:0];
         default: begin
            // Unused and time addresses leave the pins alone
         end
      endcase
   endtask

   task automatic write_setting(set_addr_t addr, set_data_t data);
      @(negedge dsp_clk);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(negedge dsp_clk);
      set_stb_i = 1'b0;
      apply_model_write(addr, data);
   endtask

   task automatic wait_cycles(int n);
      repeat (n) @(negedge dsp_clk);
   endtask

   task automatic read_word(rb_addr_t addr, output set_data_t data);
      @(negedge dsp_clk);
      rb_addr_i = addr;
      @(negedge dsp_clk);
      data = rb_data_o;
   endtask

   task automatic check_pins(logic rx_d);
      check_ctrl(clk_ctrl_t'({clock_ready_o, clk_en_o, clk_sel_o}),
                 ser_ctrl_t'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}),
                 adc_ctrl_t'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}),
                 phy_resetn_o, m_clk, m_ser, m_adc, ~m_phy);
      check_leds(leds_o, expected_leds(m_led_src, m_led_sw, run_tx_i, rx_d,
                                       clk_status_i, link_up_i));
   endtask

   task automatic wait_for_pps_seen();
      set_data_t flag;
      int        reads;
      flag  = '0;
      reads = 0;
      while (flag[0] !== 1'b1) begin
         if (reads == READ_LIMIT) begin
            stop_run("timed out waiting for pps_seen in readback word 6");
         end
         read_word(4'd6, flag);
         reads++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      set_addr_t  addr;
      set_data_t  word;
      set_data_t  secs;
      set_data_t  ticks;
      set_data_t  last_secs;
      logic [31:0] set_secs;
      logic [31:0] set_ticks;
      logic       rx_prev;
      int         pick;

      reset_i         = 1'b1;
      set_stb_i       = 1'b0;
      set_addr_i      = '0;
      set_data_i      = '0;
      pps_i           = 1'b0;
      run_rx_i        = 1'b1;
      run_tx_i        = 1'b1;
      clk_status_i    = 1'b1;
      link_up_i       = 1'b1;
      sim_mode_i      = 1'b0;
      clock_divider_i = '0;
      rb_addr_i       = '0;
      m_clk           = '0;
      m_ser           = '0;
      m_adc           = '0;
      m_phy           = 1'b0;
      m_led_sw        = '0;
      m_led_src       = `RADIO_LED_SRC_RESET;

      wait_cycles(10);
      reset_i = 1'b0;
      wait_cycles(2);

      // Reset state
      check_pins(run_rx_i);
      read_word(4'd0, word);
      check_word("rb word 0", word, 32'd6);
      read_word(4'd6, word);
      check_word("rb word 6", word, 32'd0);

      // Misc registers and unowned addresses
      for (int i = 0; i < 40; i++) begin
         if ({$random(seed)} % 2 == 0) begin
            addr = set_addr_t'({$random(seed)} % 8);
         end else begin
            pick = {$random(seed)} % 245;
            addr = (pick < 2) ? set_addr_t'(8 + pick) : set_addr_t'(11 + pick);
         end
         write_setting(addr, $random(seed));
         wait_cycles(2);
         check_pins(run_rx_i);
      end

      // LED mux against changing status inputs
      for (int i = 0; i < 8; i++) begin
         write_setting(8'd3, $random(seed));
         write_setting(8'd6, $random(seed));
         wait_cycles(2);
         check_pins(run_rx_i);
         for (int j = 0; j < 10; j++) begin
            @(negedge dsp_clk);
            rx_prev = run_rx_i;
            {run_rx_i, run_tx_i, clk_status_i, link_up_i} = $random(seed);
            #10;
            check_leds(leds_o, expected_leds(m_led_src, m_led_sw, run_tx_i, rx_prev,
                                             clk_status_i, link_up_i));
         end
      end

      // Mode word
      for (int i = 0; i < 10; i++) begin
         @(negedge dsp_clk);
         sim_mode_i      = $random(seed);
         clock_divider_i = $random(seed);
         read_word(4'd1, word);
         check_word("rb word 1", word, {sim_mode_i, 27'b0, clock_divider_i});
      end

      // Time set at the next PPS edge
      set_secs  = $random(seed);
      set_ticks = {$random(seed)} % TICKS;
      write_setting(8'd12, 32'd1);
      write_setting(8'd10, set_secs);
      write_setting(8'd11, set_ticks);
      wait_cycles(3);
      @(negedge dsp_clk);
      pps_i = 1'b1;
      wait_cycles(3);
      pps_i = 1'b0;
      wait_for_pps_seen();
      read_word(4'd4, word);
      check_word("rb word 4", word, set_secs);
      read_word(4'd5, word);
      check_word("rb word 5", word, set_ticks);

      // Immediate set close to the end of a second
      set_secs = {$random(seed)} % 1000000;
      write_setting(8'd12, 32'd0);
      write_setting(8'd10, set_secs);
      write_setting(8'd11, 32'd18);
      wait_cycles(2);
      last_secs = set_secs;
      for (int i = 0; i < 30; i++) begin
         read_word(4'd2, secs);
         read_word(4'd3, ticks);
         if (ticks >= TICKS) begin
            stop_run($sformatf("ticks read back as %0d, at or above the tick rate", ticks));
         end
         if (secs < last_secs) begin
            stop_run($sformatf("seconds fell from %0d to %0d", last_secs, secs));
         end
         last_secs = secs;
      end
      if (last_secs <= set_secs) begin
         stop_run("seconds never advanced after the immediate time set");
      end

      $display("all tests passed");
      $finish;
   end

endmodule

// File: radio_ctrl_top.f
+incdir+design
design/radio_ctrl_pkg.sv
design/time_if.sv
design/settings_decoder.sv
design/misc_ctrl_regs.sv
design/led_select.sv
design/vita_timer.sv
design/readback_mux.sv
design/radio_ctrl_top.sv
testbench/tb_radio_ctrl_top.sv
